// File: rob_commit.f
rtl/rob_pkg.sv
rtl/rob_alloc.sv
rtl/rob_entry.sv
rtl/rob_commit_count.sv
rtl/rob_top.sv
sim/rob_tb.sv

// File: rtl/rob_alloc.sv
// ROB allocation
// Owns the tail pointer, accepts one dispatch per cycle into the tail
// slot and rewinds the tail to the committed head on a flush

`timescale 1ns/100ps

module rob_alloc import rob_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   disp_valid,
	input  rob_ptr_t               head_ptr,
	input  cmt_cnt_t               retire_count,
	input  logic                   flush,
	input  rob_ptr_t               flush_ptr,
	output logic                   disp_ready,
	output rob_ndx_t               disp_tag,
	output logic [ROB_ENTRIES-1:0] alloc_we,
	output rob_ptr_t               tail_ptr
);

	logic     accept;
	logic     full_q;
	rob_ptr_t tail_next;
	rob_ptr_t head_next;
	rob_ptr_t occ_next;

	// ============================================================
	// Dispatch handshake
	// ============================================================

	// No dispatch while the ROB is full or while younger entries are
	// being thrown away
	assign disp_ready = !full_q && !flush;
	assign accept = disp_valid && disp_ready;

	// The instruction lands in the slot the tail points at
	assign disp_tag = tail_ptr[ROB_NDX_W-1:0];

	// One-hot write strobe for the tail slot
	always_comb begin
		alloc_we = '0;
		alloc_we[disp_tag] = accept;
	end

	// ============================================================
	// Tail pointer and fullness
	// ============================================================

	// Flush takes priority; dispatch is refused in that cycle anyway
	always_comb begin
		if (flush)
			tail_next = flush_ptr;
		else if (accept)
			tail_next = tail_ptr + 1'b1;
		else
			tail_next = tail_ptr;
	end

	// The commit block moves the head by the same count on this edge
	assign head_next = head_ptr + rob_ptr_t'(retire_count);

	// Occupancy after the edge follows from the two pointers
	// Wrap-around subtraction gives 0 to ROB_ENTRIES directly
	assign occ_next = tail_next - head_next;

	always_ff @(posedge clk) begin
		if (rst) begin
			tail_ptr <= '0;
			full_q <= 1'b0;
		end else begin
			tail_ptr <= tail_next;
			// Registered so that ready does not wait on the commit group
			full_q <= (occ_next == rob_ptr_t'(ROB_ENTRIES));
		end
	end

endmodule

// File: rtl/rob_commit_count.sv
// ROB commit group
// Picks how many entries at the head retire together this cycle,
// advances the head, clears the retired slots and raises a flush when
// the group ends in an exception. The commit report is registered

`timescale 1ns/100ps

module rob_commit_count import rob_pkg::*; #(
	parameter int XWID = 4
) (
	input  logic                   clk,
	input  logic                   rst,
	input  rob_ptr_t               tail_ptr,
	input  logic [ROB_ENTRIES-1:0] ent_valid,
	input  logic [ROB_ENTRIES-1:0] ent_done,
	input  logic [ROB_ENTRIES-1:0] ent_oddball,
	input  logic [ROB_ENTRIES-1:0] ent_exc,
	input  logic [ROB_ENTRIES-1:0] ent_nan,
	input  cndx_t [ROB_ENTRIES-1:0] ent_cndx,
	output rob_ptr_t               head_ptr,
	output logic [ROB_ENTRIES-1:0] retire_mask,
	output cmt_cnt_t               retire_count,
	output logic                   flush,
	output rob_ptr_t               flush_ptr,
	output logic                   cmt_valid,
	output cmt_cnt_t               cmt_count,
	output rob_ndx_t               cmt_head,
	output logic                   cmt_exc
);

	rob_ptr_t               occupancy;
	rob_ndx_t               head_ndx;
	cmt_cnt_t               grp_cnt;
	logic [ROB_ENTRIES-1:0] grp_mask;
	logic                   grp_exc;

	// Every entry between head and tail is valid, so the distance
	// between the pointers bounds the group exactly
	assign occupancy = tail_ptr - head_ptr;
	assign head_ndx = head_ptr[ROB_NDX_W-1:0];

	// ============================================================
	// Group selection
	// ============================================================

	// Walk head+0 .. head+XWID-1 and stop at the first slot that
	// cannot join the group. A slot joins when it is done, nothing
	// before it serializes or faulted, it does not bring a second
	// NaN, and it shares the head's checkpoint
	always_comb begin
		rob_ndx_t slot;
		logic     run;
		logic     ok;
		logic     nan_seen;

		grp_cnt = '0;
		grp_mask = '0;
		grp_exc = 1'b0;
		nan_seen = 1'b0;
		// While the flush is out the slots past the head are stale
		run = !flush;
		for (int i = 0; i < XWID; i++) begin
			slot = rob_ndx_t'(head_ndx + i);
			ok = run && (i < occupancy) && ent_valid[slot] && ent_done[slot]
				&& !(nan_seen && ent_nan[slot])
				&& (ent_cndx[slot] == ent_cndx[head_ndx]);
			if (ok) begin
				grp_cnt = grp_cnt + 1'b1;
				grp_mask[slot] = 1'b1;
				nan_seen = nan_seen || ent_nan[slot];
				// Only the last member of a group can carry an exception
				grp_exc = ent_exc[slot];
				if (ent_oddball[slot] || ent_exc[slot])
					run = 1'b0;
			end else begin
				run = 1'b0;
			end
		end
	end

	// Slots clear on the same edge the head moves past them
	assign retire_mask = grp_mask;
	assign retire_count = grp_cnt;

	// The head has already stepped past the faulting entry when the
	// flush is out, so it is where the tail goes back to
	assign flush_ptr = head_ptr;

	// ============================================================
	// Head pointer and commit report
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head_ptr <= '0;
			flush <= 1'b0;
			cmt_valid <= 1'b0;
			cmt_count <= '0;
			cmt_head <= '0;
			cmt_exc <= 1'b0;
		end else begin
			head_ptr <= head_ptr + rob_ptr_t'(grp_cnt);
			flush <= (grp_cnt != '0) && grp_exc;
			cmt_valid <= (grp_cnt != '0);
			cmt_count <= grp_cnt;
			cmt_head <= head_ndx;
			cmt_exc <= (grp_cnt != '0) && grp_exc;
		end
	end

endmodule

// File: rtl/rob_entry.sv
// ROB slot
// Holds one instruction's status: valid, done, serializing flag,
// exception, NaN and the checkpoint index it was dispatched under

`timescale 1ns/100ps

module rob_entry import rob_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  alloc_we,
	input  logic  disp_oddball,
	input  cndx_t disp_cndx,
	input  logic  wb_hit,
	input  logic  wb_exc,
	input  logic  wb_nan,
	input  logic  retire,
	input  logic  flush,
	output logic  ent_valid,
	output logic  ent_done,
	output logic  ent_oddball,
	output logic  ent_exc,
	output logic  ent_nan,
	output cndx_t ent_cndx
);

	// Status bits
	// Allocation is checked first, although a full ROB and a flush both
	// block dispatch, so it never meets a retire or flush on one slot
	always_ff @(posedge clk) begin
		if (rst) begin
			ent_valid <= 1'b0;
			ent_done <= 1'b0;
			ent_exc <= 1'b0;
			ent_nan <= 1'b0;
		end else if (alloc_we) begin
			ent_valid <= 1'b1;
			ent_done <= 1'b0;
			ent_exc <= 1'b0;
			ent_nan <= 1'b0;
		end else if (retire || flush) begin
			ent_valid <= 1'b0;
		end else if (wb_hit && ent_valid) begin
			// The result is back and its flags are recorded
			ent_done <= 1'b1;
			ent_exc <= wb_exc;
			ent_nan <= wb_nan;
		end
	end

	// Decode attributes only change at dispatch
	always_ff @(posedge clk) begin
		if (alloc_we) begin
			ent_oddball <= disp_oddball;
			ent_cndx <= disp_cndx;
		end
	end

endmodule

// File: rtl/rob_pkg.sv
// ROB package
// Slot count, commit width bound and the index, pointer and count types
// shared by the reorder buffer blocks

package rob_pkg;

	// ============================================================
	// Sizes
	// ============================================================

	// Number of reorder buffer slots
	localparam int ROB_ENTRIES = 8;

	// Width of a slot index
	localparam int ROB_NDX_W = $clog2(ROB_ENTRIES);

	// Upper bound on the number of entries retired in one cycle
	localparam int MAX_XWID = 4;

	// A commit count has to hold 0 through MAX_XWID inclusive
	localparam int CMT_CNT_W = $clog2(MAX_XWID + 1);

	// Checkpoint index width; four checkpoints in flight
	localparam int CNDX_W = 2;

	// ============================================================
	// Types
	// ============================================================

	// Slot index into the entry array
	typedef logic [ROB_NDX_W-1:0] rob_ndx_t;

	// Head and tail pointers carry one extra wrap bit
	// Equal pointers mean empty, pointers that differ only in the
	// wrap bit mean full
	typedef logic [ROB_NDX_W:0] rob_ptr_t;

	// Checkpoint index attached to each instruction at dispatch
	typedef logic [CNDX_W-1:0] cndx_t;

	// Number of entries retired together
	typedef logic [CMT_CNT_W-1:0] cmt_cnt_t;

endpackage

// File: rtl/rob_top.sv
// Reorder buffer top level
// Dispatch allocates at the tail, writeback marks slots done, and up to
// XWID entries (1 to 4) retire from the head each cycle

`timescale 1ns/100ps

module rob_top import rob_pkg::*; #(
	parameter int XWID = 4
) (
	input  logic     clk,
	input  logic     rst,
	// Dispatch
	input  logic     disp_valid,
	output logic     disp_ready,
	input  logic     disp_oddball,
	input  cndx_t    disp_cndx,
	output rob_ndx_t disp_tag,
	// Writeback
	input  logic     wb_valid,
	input  rob_ndx_t wb_tag,
	input  logic     wb_exc,
	input  logic     wb_nan,
	// Commit report
	output logic     cmt_valid,
	output cmt_cnt_t cmt_count,
	output rob_ndx_t cmt_head,
	output logic     cmt_exc
);

	logic [ROB_ENTRIES-1:0]  alloc_we;
	logic [ROB_ENTRIES-1:0]  retire_mask;
	logic [ROB_ENTRIES-1:0]  ent_valid;
	logic [ROB_ENTRIES-1:0]  ent_done;
	logic [ROB_ENTRIES-1:0]  ent_oddball;
	logic [ROB_ENTRIES-1:0]  ent_exc;
	logic [ROB_ENTRIES-1:0]  ent_nan;
	cndx_t [ROB_ENTRIES-1:0] ent_cndx;
	rob_ptr_t                tail_ptr;
	rob_ptr_t                head_ptr;
	rob_ptr_t                flush_ptr;
	cmt_cnt_t                retire_count;
	logic                    flush;

	rob_alloc u_alloc (
		.clk          (clk),
		.rst          (rst),
		.disp_valid   (disp_valid),
		.head_ptr     (head_ptr),
		.retire_count (retire_count),
		.flush        (flush),
		.flush_ptr    (flush_ptr),
		.disp_ready   (disp_ready),
		.disp_tag     (disp_tag),
		.alloc_we     (alloc_we),
		.tail_ptr     (tail_ptr)
	);

	// ============================================================
	// Slot array
	// ============================================================

	for (genvar g = 0; g < ROB_ENTRIES; g++) begin : g_slot
		logic wb_hit;

		// Writeback tag decode for this slot
		assign wb_hit = wb_valid && (wb_tag == rob_ndx_t'(g));

		rob_entry u_entry (
			.clk          (clk),
			.rst          (rst),
			.alloc_we     (alloc_we[g]),
			.disp_oddball (disp_oddball),
			.disp_cndx    (disp_cndx),
			.wb_hit       (wb_hit),
			.wb_exc       (wb_exc),
			.wb_nan       (wb_nan),
			.retire       (retire_mask[g]),
			.flush        (flush),
			.ent_valid    (ent_valid[g]),
			.ent_done     (ent_done[g]),
			.ent_oddball  (ent_oddball[g]),
			.ent_exc      (ent_exc[g]),
			.ent_nan      (ent_nan[g]),
			.ent_cndx     (ent_cndx[g])
		);
	end

	rob_commit_count #(
		.XWID (XWID)
	) u_commit (
		.clk          (clk),
		.rst          (rst),
		.tail_ptr     (tail_ptr),
		.ent_valid    (ent_valid),
		.ent_done     (ent_done),
		.ent_oddball  (ent_oddball),
		.ent_exc      (ent_exc),
		.ent_nan      (ent_nan),
		.ent_cndx     (ent_cndx),
		.head_ptr     (head_ptr),
		.retire_mask  (retire_mask),
		.retire_count (retire_count),
		.flush        (flush),
		.flush_ptr    (flush_ptr),
		.cmt_valid    (cmt_valid),
		.cmt_count    (cmt_count),
		.cmt_head     (cmt_head),
		.cmt_exc      (cmt_exc)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the ROB testbench with Verilator, runs it, and exits non-zero
# unless the run printed the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module rob_tb \
	-f rob_commit.f --Mdir obj_dir -o rob_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/rob_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q '^RESULT: PASS$'; then
	exit 0
fi

echo "Pass line not found in simulation output"
exit 1

// File: sim/rob_tb.sv
// ROB testbench
// Random dispatch and writeback traffic against a queue model of the
// ROB; a reference function predicts each commit group and a separate
// process compares the registered report one cycle later

`timescale 1ns/100ps

module rob_tb import rob_pkg::*; ();

	localparam int XWID = 4;
	localparam int CLK_NS = 4;
	localparam int PHASE_LEN = 250;
	localparam int N_CYCLES = 5 * PHASE_LEN;

	// One outstanding instruction as the model sees it
	typedef struct packed {
		rob_ndx_t tag;
		logic     done;
		logic     oddball;
		logic     exc;
		logic     nan;
		cndx_t    cndx;
	} model_ent_t;

	logic     clk = 1'b0;
	logic     rst;
	logic     disp_valid;
	logic     disp_ready;
	logic     disp_oddball;
	cndx_t    disp_cndx;
	rob_ndx_t disp_tag;
	logic     wb_valid;
	rob_ndx_t wb_tag;
	logic     wb_exc;
	logic     wb_nan;
	logic     cmt_valid;
	cmt_cnt_t cmt_count;
	rob_ndx_t cmt_head;
	logic     cmt_exc;

	integer   seed = 32'h16916001;

	// Model state as it stands after the most recent edge
	model_ent_t model_q[$];
	rob_ndx_t   m_head;
	rob_ndx_t   m_tail;
	logic       m_full;
	logic       m_flush;
	cndx_t      cur_cndx;

	// What the outputs should show this cycle, and the group picked now
	logic       rep_valid;
	cmt_cnt_t   rep_count;
	rob_ndx_t   rep_head;
	logic       rep_exc;
	logic       rep_ready;
	rob_ndx_t   rep_tag;
	logic       nxt_valid;
	cmt_cnt_t   nxt_count;
	rob_ndx_t   nxt_head;
	logic       nxt_exc;

	logic       seen_group4;
	logic       seen_exc;
	logic       seen_full;

	rob_top #(
		.XWID (XWID)
	) uut (
		.clk          (clk),
		.rst          (rst),
		.disp_valid   (disp_valid),
		.disp_ready   (disp_ready),
		.disp_oddball (disp_oddball),
		.disp_cndx    (disp_cndx),
		.disp_tag     (disp_tag),
		.wb_valid     (wb_valid),
		.wb_tag       (wb_tag),
		.wb_exc       (wb_exc),
		.wb_nan       (wb_nan),
		.cmt_valid    (cmt_valid),
		.cmt_count    (cmt_count),
		.cmt_head     (cmt_head),
		.cmt_exc      (cmt_exc)
	);

	always #(CLK_NS / 2) clk = ~clk;

	// ============================================================
	// Failure reporting and compare tasks
	// ============================================================

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_bit(input string name, input logic exp_val, input logic act_val);
		if (act_val !== exp_val)
			fail_stop($sformatf("ERROR at %0d ns: %s expected %0b, got %0b",
				$time, name, exp_val, act_val));
	endtask

	task automatic check_count(input string name, input cmt_cnt_t exp_val,
			input cmt_cnt_t act_val);
		if (act_val !== exp_val)
			fail_stop($sformatf("ERROR at %0d ns: %s expected %0d, got %0d",
				$time, name, exp_val, act_val));
	endtask

	task automatic check_tag(input string name, input rob_ndx_t exp_val,
			input rob_ndx_t act_val);
		if (act_val !== exp_val)
			fail_stop($sformatf("ERROR at %0d ns: %s expected %0d, got %0d",
				$time, name, exp_val, act_val));
	endtask

	// ============================================================
	// Reference commit rule and random helpers
	// ============================================================

	// The group is the leading run from the oldest instruction. Each member
	// must be done, follow no serializing or faulting member, keep the NaN
	// count at one and share the oldest instruction's checkpoint
	function automatic cmt_cnt_t expected_commit(output logic grp_exc);
		int       limit;
		int       nans;
		cmt_cnt_t cnt;

		cnt = '0;
		nans = 0;
		grp_exc = 1'b0;
		limit = (model_q.size() < XWID) ? model_q.size() : XWID;
		for (int i = 0; i < limit; i++) begin
			if (!model_q[i].done)
				break;
			if (i > 0 && (model_q[i-1].oddball || model_q[i-1].exc))
				break;
			if (model_q[i].cndx != model_q[0].cndx)
				break;
			if (model_q[i].nan)
				nans = nans + 1;
			if (nans > 1)
				break;
			cnt = cnt + 1'b1;
			grp_exc = model_q[i].exc;
		end
		return cnt;
	endfunction

	function automatic logic roll_percent(input int pct);
		return ($unsigned($random(seed)) % 100) < pct;
	endfunction

	function automatic int pick_index(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// ============================================================
	// One cycle of stimulus and model update
	// ============================================================

	task automatic run_cycle(input int cyc);
		cmt_cnt_t   gcnt;
		logic       gexc;
		int         p_disp;
		int         p_wb;
		int         p_odd;
		int         p_exc;
		int         p_nan;
		int         p_cndx;
		int         cand[$];
		int         pick;
		logic       youngest_first;
		logic       do_wb;
		model_ent_t ent;

		// The registered report showing now was decided last cycle
		rep_valid = nxt_valid;
		rep_count = nxt_count;
		rep_head = nxt_head;
		rep_exc = nxt_exc;
		rep_ready = !m_full && !m_flush;
		rep_tag = m_tail;
		if (m_full)
			seen_full = 1'b1;

		gcnt = expected_commit(gexc);

		// Each phase has its own traffic mix. They run plain, boundaries,
		// NaN and checkpoints, fill and drain, and last everything together
		p_disp = 70;
		p_wb = 80;
		p_odd = 0;
		p_exc = 0;
		p_nan = 0;
		p_cndx = 0;
		youngest_first = 1'b0;
		case (cyc / PHASE_LEN)
			0: ;
			1: begin
				p_odd = 15;
				p_exc = 10;
			end
			2: begin
				p_nan = 40;
				p_cndx = 20;
			end
			3: begin
				// Fill to full with no results back, then finish youngest first
				youngest_first = 1'b1;
				p_disp = ((cyc - 3 * PHASE_LEN) % 25 < 12) ? 100 : 0;
				p_wb = ((cyc - 3 * PHASE_LEN) % 25 < 12) ? 0 : 100;
			end
			4: begin
				p_disp = 75;
				p_odd = 8;
				p_exc = 5;
				p_nan = 25;
				p_cndx = 10;
			end
			default: begin
				p_disp = 0;
				p_wb = 0;
			end
		endcase

		// Results come back for any outstanding instruction not yet done
		do_wb = 1'b0;
		pick = 0;
		for (int i = 0; i < model_q.size(); i++)
			if (!model_q[i].done)
				cand.push_back(i);
		if (cand.size() != 0 && roll_percent(p_wb)) begin
			do_wb = 1'b1;
			pick = youngest_first ? cand[cand.size()-1] : cand[pick_index(cand.size())];
		end

		disp_valid = roll_percent(p_disp);
		disp_oddball = roll_percent(p_odd);
		if (roll_percent(p_cndx))
			cur_cndx = cur_cndx + 1'b1;
		disp_cndx = cur_cndx;
		wb_valid = do_wb;
		wb_tag = do_wb ? model_q[pick].tag : '0;
		wb_exc = roll_percent(p_exc);
		wb_nan = roll_percent(p_nan);

		nxt_valid = (gcnt != '0);
		nxt_count = gcnt;
		nxt_head = m_head;
		nxt_exc = (gcnt != '0) && gexc;
		if (gcnt == cmt_cnt_t'(4))
			seen_group4 = 1'b1;
		if (nxt_exc)
			seen_exc = 1'b1;

		// Effects of the coming edge
		if (do_wb) begin
			ent = model_q[pick];
			ent.done = 1'b1;
			ent.exc = wb_exc;
			ent.nan = wb_nan;
			model_q[pick] = ent;
		end
		for (int i = 0; i < int'(gcnt); i++)
			void'(model_q.pop_front());
		m_head = m_head + rob_ndx_t'(gcnt);
		m_flush = 1'b0;
		if (disp_valid && rep_ready) begin
			ent = '0;
			ent.tag = m_tail;
			ent.oddball = disp_oddball;
			ent.cndx = disp_cndx;
			model_q.push_back(ent);
			m_tail = m_tail + 1'b1;
		end
		// A faulting commit throws away everything younger, including
		// a dispatch taken on the same edge
		if (nxt_exc) begin
			model_q.delete();
			m_tail = m_head;
			m_flush = 1'b1;
		end
		m_full = (model_q.size() == ROB_ENTRIES);
	endtask

	// ============================================================
	// Processes
	// ============================================================

	initial begin
		rst = 1'b1;
		disp_valid = 1'b0;
		disp_oddball = 1'b0;
		disp_cndx = '0;
		wb_valid = 1'b0;
		wb_tag = '0;
		wb_exc = 1'b0;
		wb_nan = 1'b0;
		m_head = '0;
		m_tail = '0;
		m_full = 1'b0;
		m_flush = 1'b0;
		cur_cndx = '0;
		rep_valid = 1'b0;
		rep_count = '0;
		rep_head = '0;
		rep_exc = 1'b0;
		rep_ready = 1'b1;
		rep_tag = '0;
		nxt_valid = 1'b0;
		nxt_count = '0;
		nxt_head = '0;
		nxt_exc = 1'b0;
		seen_group4 = 1'b0;
		seen_exc = 1'b0;
		seen_full = 1'b0;

		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int cyc = 0; cyc < N_CYCLES; cyc++) begin
			run_cycle(cyc);
			@(posedge clk);
			#1;
		end
		// One idle cycle so the last group's report is compared too
		run_cycle(N_CYCLES);
		@(negedge clk);
		#1;

		if (!seen_group4 || !seen_exc || !seen_full) begin
			fail_stop($sformatf(
				"Stimulus missed a case: group of four %0b, exception %0b, full %0b",
				seen_group4, seen_exc, seen_full));
		end else begin
			$display("RESULT: PASS");
			$finish;
		end
	end

	// Outputs are compared mid-cycle where they are stable
	initial begin
		@(posedge clk);
		forever begin
			@(negedge clk);
			check_bit("cmt_valid", rep_valid, cmt_valid);
			check_bit("cmt_exc", rep_exc, cmt_exc);
			check_count("cmt_count", rep_count, cmt_count);
			if (rep_valid)
				check_tag("cmt_head", rep_head, cmt_head);
			check_bit("disp_ready", rep_ready, disp_ready);
			if (rep_ready)
				check_tag("disp_tag", rep_tag, disp_tag);
		end
	end

	// Watchdog sized from the test length plus a 200 cycle margin
	initial begin
		#((N_CYCLES + 200) * CLK_NS);
		fail_stop("Timeout: the test did not finish within the expected number of cycles");
	end

endmodule
